/* source/sr_pkg.sv */
package sr_pkg;

    // ======================================================================
    // Sample types
    // ======================================================================

    typedef logic [7:0] pixel_t;            // Unsigned colour value as it enters and leaves
    typedef logic signed [9:0] sample_t;    // Centred value, (pixel - 128) << 2
    typedef logic signed [13:0] acc_t;      // Holds the full kernel sum without overflow

    // ======================================================================
    // Channels and filter weights
    // ======================================================================

    localparam int NUM_CHANNELS = 3;        // Red, green, blue

    // Sharpening kernel: centre tap and its four edge neighbours, corners are zero
    localparam int W_CENTER = 5;
    localparam int W_CROSS = -1;

    // ======================================================================
    // Saturation bounds of sample_t
    // ======================================================================

    localparam int SAMPLE_MAX = 511;
    localparam int SAMPLE_MIN = -512;

endpackage : sr_pkg

/* source/pixel_stream_if.sv */
`timescale 1ns/1ns

interface pixel_stream_if import sr_pkg::*; ();

    logic valid;
    logic ready;
    sample_t red;
    sample_t green;
    sample_t blue;

    // Data and valid stay steady until the transfer, ready never looks at valid
    modport source (
        output valid,
        output red,
        output green,
        output blue,
        input  ready
    );

    modport sink (
        input  valid,
        input  red,
        input  green,
        input  blue,
        output ready
    );

endinterface : pixel_stream_if

/* source/pixel_codec.sv */
`timescale 1ns/1ns

module pixel_codec import sr_pkg::*; #(
    parameter int Height = 480,
    parameter int Width = 640
) (
    input  logic clock_i,
    input  logic reset_i,

    input  logic slave_valid_i,
    output logic slave_ready_o,
    input  pixel_t slave_red_i,
    input  pixel_t slave_green_i,
    input  pixel_t slave_blue_i,

    output logic master_valid_o,
    input  logic master_ready_i,
    output pixel_t master_red_o,
    output pixel_t master_green_o,
    output pixel_t master_blue_o,
    output logic master_last_o,

    pixel_stream_if.source to_core_o,
    pixel_stream_if.sink from_core_i
);

    typedef logic [$clog2(Height)-1:0] row_t;
    typedef logic [$clog2(Width)-1:0] column_t;

    row_t row_q;
    column_t column_q;

    function automatic sample_t to_sample(pixel_t value);
        sample_t centred;
        centred = sample_t'({2'b00, value}) - sample_t'(128);
        return centred <<< 2;
    endfunction : to_sample

    function automatic pixel_t to_pixel(sample_t value);
        sample_t shifted;
        shifted = value >>> 2;
        if (shifted >= sample_t'(127)) begin
            return 8'd255;
        end else if (shifted <= sample_t'(-128)) begin
            return 8'd0;
        end
        return pixel_t'(shifted + sample_t'(128));
    endfunction : to_pixel

    // ======================================================================
    // Input side, purely combinational
    // ======================================================================

    assign to_core_o.valid = slave_valid_i;
    assign slave_ready_o = to_core_o.ready;
    assign to_core_o.red = to_sample(slave_red_i);
    assign to_core_o.green = to_sample(slave_green_i);
    assign to_core_o.blue = to_sample(slave_blue_i);

    // ======================================================================
    // Output side with frame position
    // ======================================================================

    assign master_valid_o = from_core_i.valid;
    assign from_core_i.ready = master_ready_i;
    assign master_red_o = to_pixel(from_core_i.red);
    assign master_green_o = to_pixel(from_core_i.green);
    assign master_blue_o = to_pixel(from_core_i.blue);

    always_ff @(posedge clock_i) begin
        if (!reset_i) begin
            row_q <= '0;
            column_q <= '0;
        end else if (from_core_i.valid && master_ready_i) begin
            if (column_q == column_t'(Width - 1)) begin
                column_q <= '0;
                row_q <= (row_q == row_t'(Height - 1)) ? '0 : row_q + 1'b1;
            end else begin
                column_q <= column_q + 1'b1;
            end
        end
    end

    assign master_last_o = (row_q == row_t'(Height - 1)) && (column_q == column_t'(Width - 1));

endmodule : pixel_codec

/* source/window_buffer.sv */
`timescale 1ns/1ns

module window_buffer import sr_pkg::*; #(
    parameter int Height = 480,
    parameter int Width = 640
) (
    input  logic clock_i,
    input  logic reset_i,

    pixel_stream_if.sink in_i,

    output logic win_valid_o,
    input  logic win_ready_i,
    output sample_t [NUM_CHANNELS-1:0] win_up_o,
    output sample_t [NUM_CHANNELS-1:0] win_left_o,
    output sample_t [NUM_CHANNELS-1:0] win_center_o,
    output sample_t [NUM_CHANNELS-1:0] win_right_o,
    output sample_t [NUM_CHANNELS-1:0] win_down_o
);

    typedef logic [$clog2(Height)-1:0] row_t;
    typedef logic [$clog2(Width)-1:0] column_t;

    row_t row_q;
    column_t column_q;
    logic take;
    logic row_ge1, row_ge2, col_ge1, col_ge2;

    sample_t line1_mem [NUM_CHANNELS][Width];      // Row r-1
    sample_t line2_mem [NUM_CHANNELS][Width];      // Row r-2

    sample_t [NUM_CHANNELS-1:0] pixel;
    sample_t [NUM_CHANNELS-1:0] above1;            // (r-1, c)
    sample_t [NUM_CHANNELS-1:0] above2;            // (r-2, c)
    sample_t [NUM_CHANNELS-1:0] above1_d1;         // (r-1, c-1)
    sample_t [NUM_CHANNELS-1:0] above1_d2;         // (r-1, c-2)
    sample_t [NUM_CHANNELS-1:0] above2_d1;         // (r-2, c-1)
    sample_t [NUM_CHANNELS-1:0] pixel_d1;          // (r, c-1)

    assign pixel = {in_i.blue, in_i.green, in_i.red};
    assign in_i.ready = !win_valid_o || win_ready_i;   // One-entry stage
    assign take = in_i.valid && in_i.ready;

    always_comb begin
        for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
            above1[ch] = line1_mem[ch][column_q];
            above2[ch] = line2_mem[ch][column_q];
        end
    end

    // Causal position flags, anything before row 0 or column 0 is padding
    assign row_ge1 = int'(row_q) >= 1;
    assign row_ge2 = int'(row_q) >= 2;
    assign col_ge1 = int'(column_q) >= 1;
    assign col_ge2 = int'(column_q) >= 2;

    // ======================================================================
    // Position of the incoming pixel in its frame
    // ======================================================================

    always_ff @(posedge clock_i) begin
        if (!reset_i) begin
            row_q <= '0;
            column_q <= '0;
        end else if (take) begin
            if (column_q == column_t'(Width - 1)) begin
                column_q <= '0;
                row_q <= (row_q == row_t'(Height - 1)) ? '0 : row_q + 1'b1;
            end else begin
                column_q <= column_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clock_i) begin
        if (!reset_i) begin
            win_valid_o <= 1'b0;
        end else if (in_i.ready) begin
            win_valid_o <= in_i.valid;
        end
    end

    // ======================================================================
    // Line memories, column shift registers and masked window taps
    // ======================================================================

    always_ff @(posedge clock_i) begin
        if (take) begin
            for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
                win_up_o[ch] <= (row_ge2 && col_ge1) ? above2_d1[ch] : '0;
                win_left_o[ch] <= (row_ge1 && col_ge2) ? above1_d2[ch] : '0;
                win_center_o[ch] <= (row_ge1 && col_ge1) ? above1_d1[ch] : '0;
                win_right_o[ch] <= row_ge1 ? above1[ch] : '0;
                win_down_o[ch] <= col_ge1 ? pixel_d1[ch] : '0;

                line2_mem[ch][column_q] <= above1[ch];     // Rows move up by one
                line1_mem[ch][column_q] <= pixel[ch];

                above2_d1[ch] <= above2[ch];
                above1_d2[ch] <= above1_d1[ch];
                above1_d1[ch] <= above1[ch];
                pixel_d1[ch] <= pixel[ch];
            end
        end
    end

endmodule : window_buffer

/* source/sharpen_conv.sv */
`timescale 1ns/1ns

module sharpen_conv import sr_pkg::*; (
    input  logic clock_i,
    input  logic reset_i,

    input  logic win_valid_i,
    output logic win_ready_o,
    input  sample_t [NUM_CHANNELS-1:0] win_up_i,
    input  sample_t [NUM_CHANNELS-1:0] win_left_i,
    input  sample_t [NUM_CHANNELS-1:0] win_center_i,
    input  sample_t [NUM_CHANNELS-1:0] win_right_i,
    input  sample_t [NUM_CHANNELS-1:0] win_down_i,

    pixel_stream_if.source out_o
);

    logic s1_valid_q, s2_valid_q;
    logic s1_advance, s2_advance;

    acc_t [NUM_CHANNELS-1:0] up_prod_q, left_prod_q, center_prod_q;
    acc_t [NUM_CHANNELS-1:0] right_prod_q, down_prod_q;
    acc_t [NUM_CHANNELS-1:0] sum;
    sample_t [NUM_CHANNELS-1:0] result_q;

    function automatic acc_t weigh(sample_t tap, int weight);
        return acc_t'(tap) * acc_t'(weight);
    endfunction : weigh

    function automatic sample_t saturate(acc_t value);
        if (value > acc_t'(SAMPLE_MAX)) begin
            return sample_t'(SAMPLE_MAX);
        end else if (value < acc_t'(SAMPLE_MIN)) begin
            return sample_t'(SAMPLE_MIN);
        end
        return sample_t'(value);
    endfunction : saturate

    // A stage moves when the one after it is empty or being emptied
    assign s2_advance = !s2_valid_q || out_o.ready;
    assign s1_advance = !s1_valid_q || s2_advance;
    assign win_ready_o = s1_advance;

    always_ff @(posedge clock_i) begin
        if (!reset_i) begin
            s1_valid_q <= 1'b0;
            s2_valid_q <= 1'b0;
        end else begin
            if (s1_advance) begin
                s1_valid_q <= win_valid_i;
            end
            if (s2_advance) begin
                s2_valid_q <= s1_valid_q;
            end
        end
    end

    // ======================================================================
    // Stage one, products
    // ======================================================================

    always_ff @(posedge clock_i) begin
        if (s1_advance && win_valid_i) begin
            for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
                up_prod_q[ch] <= weigh(win_up_i[ch], W_CROSS);
                left_prod_q[ch] <= weigh(win_left_i[ch], W_CROSS);
                center_prod_q[ch] <= weigh(win_center_i[ch], W_CENTER);
                right_prod_q[ch] <= weigh(win_right_i[ch], W_CROSS);
                down_prod_q[ch] <= weigh(win_down_i[ch], W_CROSS);
            end
        end
    end

    // ======================================================================
    // Stage two, sum and saturation
    // ======================================================================

    always_comb begin
        for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
            sum[ch] = center_prod_q[ch] + up_prod_q[ch] + left_prod_q[ch]
                    + right_prod_q[ch] + down_prod_q[ch];
        end
    end

    always_ff @(posedge clock_i) begin
        if (s2_advance && s1_valid_q) begin
            for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
                result_q[ch] <= saturate(sum[ch]);
            end
        end
    end

    assign out_o.valid = s2_valid_q;
    assign out_o.red = result_q[0];
    assign out_o.green = result_q[1];
    assign out_o.blue = result_q[2];

endmodule : sharpen_conv

/* source/srcnn_small.sv */
`timescale 1ns/1ns

module srcnn_small import sr_pkg::*; #(
    parameter int Height = 480,
    parameter int Width = 640
) (
    input  logic clock_i,
    input  logic reset_i,
    pixel_stream_if.sink in_i,
    pixel_stream_if.source out_o
);

    logic win_valid;
    logic win_ready;
    sample_t [NUM_CHANNELS-1:0] win_up, win_left, win_center, win_right, win_down;

    window_buffer #(
        .Height(Height),
        .Width (Width)
    ) window_buffer_inst (
        .clock_i     (clock_i),
        .reset_i     (reset_i),
        .in_i        (in_i),
        .win_valid_o (win_valid),
        .win_ready_i (win_ready),
        .win_up_o    (win_up),
        .win_left_o  (win_left),
        .win_center_o(win_center),
        .win_right_o (win_right),
        .win_down_o  (win_down)
    );

    sharpen_conv sharpen_conv_inst (
        .clock_i     (clock_i),
        .reset_i     (reset_i),
        .win_valid_i (win_valid),
        .win_ready_o (win_ready),
        .win_up_i    (win_up),
        .win_left_i  (win_left),
        .win_center_i(win_center),
        .win_right_i (win_right),
        .win_down_i  (win_down),
        .out_o       (out_o)
    );

endmodule : srcnn_small

/* source/superresolution.sv */
`timescale 1ns/1ns

module superresolution import sr_pkg::*; #(
    parameter int Height = 480,
    parameter int Width = 640
) (
    input  logic clock_i,
    input  logic reset_i,

    input  logic slave_valid_i,
    output logic slave_ready_o,
    input  pixel_t slave_red_i,
    input  pixel_t slave_green_i,
    input  pixel_t slave_blue_i,

    output logic master_valid_o,
    input  logic master_ready_i,
    output pixel_t master_red_o,
    output pixel_t master_green_o,
    output pixel_t master_blue_o,
    output logic master_last_o
);

    pixel_stream_if to_core ();     // Centred samples into the filter
    pixel_stream_if from_core ();   // Filtered samples back out

    pixel_codec #(
        .Height(Height),
        .Width (Width)
    ) pixel_codec_inst (
        .clock_i       (clock_i),
        .reset_i       (reset_i),
        .slave_valid_i (slave_valid_i),
        .slave_ready_o (slave_ready_o),
        .slave_red_i   (slave_red_i),
        .slave_green_i (slave_green_i),
        .slave_blue_i  (slave_blue_i),
        .master_valid_o(master_valid_o),
        .master_ready_i(master_ready_i),
        .master_red_o  (master_red_o),
        .master_green_o(master_green_o),
        .master_blue_o (master_blue_o),
        .master_last_o (master_last_o),
        .to_core_o     (to_core),
        .from_core_i   (from_core)
    );

    srcnn_small #(
        .Height(Height),
        .Width (Width)
    ) srcnn_small_inst (
        .clock_i(clock_i),
        .reset_i(reset_i),
        .in_i   (to_core),
        .out_o  (from_core)
    );

endmodule : superresolution

/* verif/sr_sva.sv */
`timescale 1ns/1ns

module sr_sva import sr_pkg::*; (
    input logic clock_i,
    input logic reset_i,
    input logic slave_valid_i,
    input logic slave_ready_i,
    input pixel_t slave_red_i,
    input pixel_t slave_green_i,
    input pixel_t slave_blue_i,
    input logic master_valid_i,
    input logic master_ready_i,
    input pixel_t master_red_i,
    input pixel_t master_green_i,
    input pixel_t master_blue_i,
    input logic master_last_i
);

    int failure_count = 0;

    // ======================================================================
    // Stream stability while waiting for ready
    // ======================================================================

    property hold_output_stream;
        @(posedge clock_i) disable iff (!reset_i)
        master_valid_i && !master_ready_i |=> master_valid_i && $stable(master_red_i)
            && $stable(master_green_i) && $stable(master_blue_i) && $stable(master_last_i);
    endproperty

    property hold_input_stream;
        @(posedge clock_i) disable iff (!reset_i)
        slave_valid_i && !slave_ready_i |=> slave_valid_i && $stable(slave_red_i)
            && $stable(slave_green_i) && $stable(slave_blue_i);
    endproperty

    // Pipeline is empty and ready right after reset
    property quiet_after_reset;
        @(posedge clock_i) $rose(reset_i) |-> slave_ready_i && !master_valid_i ##1 !master_valid_i;
    endproperty

    assert property (hold_output_stream) else begin
        $error("Output stream changed while stalled");
        failure_count++;
    end

    assert property (hold_input_stream) else begin
        $error("Input stream changed while stalled");
        failure_count++;
    end

    assert property (quiet_after_reset) else begin
        $error("Pipeline not idle after reset release");
        failure_count++;
    end

endmodule : sr_sva

bind superresolution sr_sva sr_sva_inst (
    .clock_i       (clock_i),
    .reset_i       (reset_i),
    .slave_valid_i (slave_valid_i),
    .slave_ready_i (slave_ready_o),
    .slave_red_i   (slave_red_i),
    .slave_green_i (slave_green_i),
    .slave_blue_i  (slave_blue_i),
    .master_valid_i(master_valid_o),
    .master_ready_i(master_ready_i),
    .master_red_i  (master_red_o),
    .master_green_i(master_green_o),
    .master_blue_i (master_blue_o),
    .master_last_i (master_last_o)
);

/* verif/sr_checker.sv */
`timescale 1ns/1ns

module sr_checker import sr_pkg::*; #(
    parameter int Height = 6,
    parameter int Width = 8,
    parameter int Depth = 1024
) (
    input  logic clock_i,
    input  logic reset_i,
    input  logic slave_valid_i,
    input  logic slave_ready_i,
    input  pixel_t slave_red_i,
    input  pixel_t slave_green_i,
    input  pixel_t slave_blue_i,
    input  logic master_valid_i,
    input  logic master_ready_i,
    input  pixel_t master_red_i,
    input  pixel_t master_green_i,
    input  pixel_t master_blue_i,
    input  logic master_last_i,
    output int mismatch_count_o,
    output int other_count_o,
    output int checked_count_o
);

    localparam int FramePixels = Height * Width;

    pixel_t in_pixels [3][Depth];       // Accepted inputs by absolute input count
    int accepted = 0;
    int checked = 0;
    int mismatches = 0;
    int others = 0;

    assign mismatch_count_o = mismatches;
    assign other_count_o = others;
    assign checked_count_o = checked;

    // Centred and scaled input value, zero outside the causal frame
    function automatic int tap(int base, int row, int col, int ch);
        if (row < 0 || col < 0) begin
            return 0;
        end
        return (int'(in_pixels[ch][(base + row * Width + col) % Depth]) - 128) * 4;
    endfunction : tap

    function automatic int expected_pixel(int index, int ch);
        int base;
        int pos;
        int row;
        int col;
        int acc;
        base = (index / FramePixels) * FramePixels;
        pos = index % FramePixels;
        row = pos / Width;
        col = pos % Width;
        acc = 5 * tap(base, row - 1, col - 1, ch) - tap(base, row - 2, col - 1, ch)
            - tap(base, row - 1, col - 2, ch) - tap(base, row - 1, col, ch)
            - tap(base, row, col - 1, ch);
        if (acc > 511) begin
            acc = 511;
        end else if (acc < -512) begin
            acc = -512;
        end
        acc = acc >>> 2;
        if (acc >= 127) begin
            return 255;
        end else if (acc <= -128) begin
            return 0;
        end
        return acc + 128;
    endfunction : expected_pixel

    task automatic compare_value(input string name, input int expected, input int actual);
        if (expected != actual) begin
            mismatches++;
            $display("FAILED at %0t ns: %s expected %0d, got %0d", $time, name, expected, actual);
        end
    endtask : compare_value

    // ======================================================================
    // Compare outputs first, then record the input taken at the same edge
    // ======================================================================

    always @(posedge clock_i) begin
        if (reset_i) begin
            if (master_valid_i && master_ready_i) begin
                if (checked >= accepted) begin
                    others++;
                    $display("Output pixel at %0t ns has no matching input pixel", $time);
                end else begin
                    compare_value("master_red_o", expected_pixel(checked, 0), master_red_i);
                    compare_value("master_green_o", expected_pixel(checked, 1), master_green_i);
                    compare_value("master_blue_o", expected_pixel(checked, 2), master_blue_i);
                    compare_value("master_last_o", int'(checked % FramePixels == FramePixels - 1),
                                  int'(master_last_i));
                end
                checked++;
            end
            if (slave_valid_i && slave_ready_i) begin
                in_pixels[0][accepted % Depth] = slave_red_i;
                in_pixels[1][accepted % Depth] = slave_green_i;
                in_pixels[2][accepted % Depth] = slave_blue_i;
                accepted++;
            end
        end
    end

endmodule : sr_checker

/* verif/tb_superresolution.sv */
`timescale 1ns/1ns

module tb_superresolution import sr_pkg::*;;

    localparam int HEIGHT = 6;
    localparam int WIDTH = 8;
    localparam int FRAME_PIXELS = HEIGHT * WIDTH;
    localparam int NUM_FRAMES = 9;
    localparam int CLOCK_PERIOD = 20;
    localparam int TIMEOUT_CYCLES = NUM_FRAMES * FRAME_PIXELS * 4 + 200;

    logic clock_i = 1'b0;
    logic reset_i;
    logic slave_valid_i;
    logic slave_ready_o;
    pixel_t slave_red_i, slave_green_i, slave_blue_i;
    logic master_valid_o;
    logic master_ready_i;
    pixel_t master_red_o, master_green_o, master_blue_o;
    logic master_last_o;

    int mismatch_count, other_count, checked_count;
    int assertion_count;
    int sent_count = 0;
    logic random_ready;
    logic [31:0] stim_state = 32'd39891;
    logic [31:0] ready_state = 32'd39891;

    always #(CLOCK_PERIOD / 2) clock_i = ~clock_i;

    superresolution #(.Height(HEIGHT), .Width(WIDTH)) superresolution_i (.*);

    sr_checker #(.Height(HEIGHT), .Width(WIDTH)) checker_inst (
        .clock_i, .reset_i, .slave_valid_i,
        .slave_ready_i   (slave_ready_o),
        .slave_red_i, .slave_green_i, .slave_blue_i,
        .master_valid_i  (master_valid_o),
        .master_ready_i,
        .master_red_i    (master_red_o),
        .master_green_i  (master_green_o),
        .master_blue_i   (master_blue_o),
        .master_last_i   (master_last_o),
        .mismatch_count_o(mismatch_count),
        .other_count_o   (other_count),
        .checked_count_o (checked_count)
    );

    assign assertion_count = superresolution_i.sr_sva_inst.failure_count;

    function automatic logic [31:0] xorshift32(input logic [31:0] state);
        logic [31:0] s;
        s = state;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction : xorshift32

    // Downstream ready is high about three cycles in four when random
    always @(posedge clock_i) begin
        if (random_ready) begin
            ready_state = xorshift32(ready_state);
            master_ready_i <= ready_state[9:8] != 2'b00;
        end else begin
            master_ready_i <= 1'b1;
        end
    end

    // Holds the pixel until the edge where slave_ready_o is seen high
    task automatic send_pixel(input pixel_t red, input pixel_t green, input pixel_t blue,
                              input bit with_gaps);
        if (with_gaps) begin
            stim_state = xorshift32(stim_state);
            while (stim_state[3:2] == 2'b00) begin
                slave_valid_i <= 1'b0;
                @(posedge clock_i);
                stim_state = xorshift32(stim_state);
            end
        end
        slave_valid_i <= 1'b1;
        slave_red_i <= red;
        slave_green_i <= green;
        slave_blue_i <= blue;
        @(posedge clock_i);
        while (!slave_ready_o) begin
            @(posedge clock_i);
        end
        sent_count++;
    endtask : send_pixel

    task automatic send_flat_frame(input pixel_t value);
        for (int i = 0; i < FRAME_PIXELS; i++) begin
            send_pixel(value, value, value, 1'b0);
        end
    endtask : send_flat_frame

    task automatic send_random_frame(input bit with_gaps);
        logic [31:0] word;
        for (int i = 0; i < FRAME_PIXELS; i++) begin
            stim_state = xorshift32(stim_state);
            word = stim_state;
            send_pixel(word[7:0], word[15:8], word[23:16], with_gaps);
        end
    endtask : send_random_frame

    task automatic send_checkerboard_frame(input bit inverted);
        pixel_t value;
        for (int row = 0; row < HEIGHT; row++) begin
            for (int col = 0; col < WIDTH; col++) begin
                value = (((row + col) % 2 == 0) ^ inverted) ? 8'd255 : 8'd0;
                send_pixel(value, ~value, value, 1'b0);    // Green runs opposite
            end
        end
    endtask : send_checkerboard_frame

    // ======================================================================
    // Watchdog
    // ======================================================================

    initial begin
        #(TIMEOUT_CYCLES * CLOCK_PERIOD);
        $display("Timeout after %0d cycles with %0d of %0d pixels checked",
                 TIMEOUT_CYCLES, checked_count, sent_count);
        $display("Closing counts: %0d value mismatches, %0d other errors, %0d pixels checked",
                 mismatch_count, other_count + assertion_count + 1, checked_count);
        $display("Verification failed");
        $finish;
    end

    // ======================================================================
    // Stimulus phases
    // ======================================================================

    initial begin
        reset_i = 1'b0;
        slave_valid_i = 1'b0;
        slave_red_i = '0;
        slave_green_i = '0;
        slave_blue_i = '0;
        master_ready_i = 1'b1;
        random_ready = 1'b0;
        repeat (8) @(posedge clock_i);
        reset_i <= 1'b1;
        @(posedge clock_i);

        send_flat_frame(8'd128);
        send_flat_frame(8'd200);
        send_random_frame(1'b0);
        send_random_frame(1'b0);

        random_ready <= 1'b1;     // Three frames back to back under stalls
        repeat (3) send_random_frame(1'b1);
        random_ready <= 1'b0;

        send_checkerboard_frame(1'b0);
        send_checkerboard_frame(1'b1);
        slave_valid_i <= 1'b0;

        wait (checked_count == sent_count);
        repeat (10) @(posedge clock_i);
        $display("Closing counts: %0d value mismatches, %0d other errors, %0d pixels checked",
                 mismatch_count, other_count + assertion_count, checked_count);
        if (mismatch_count == 0 && other_count == 0 && assertion_count == 0
                && checked_count == sent_count) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule : tb_superresolution

/* list.f */
source/sr_pkg.sv
source/pixel_stream_if.sv
source/pixel_codec.sv
source/window_buffer.sv
source/sharpen_conv.sv
source/srcnn_small.sv
source/superresolution.sv
verif/sr_sva.sv
verif/sr_checker.sv
verif/tb_superresolution.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_superresolution
FILELIST  ?= list.f
BUILD_DIR ?= build
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if grep -q "Verification failed" $(LOG); then \
		echo "Simulation reported failure, see $(LOG)"; exit 1; \
	fi; \
	if [ $$status -ne 0 ] || ! grep -q "Verification passed" $(LOG); then \
		echo "Simulation ended abnormally, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
